// ==== csr_issue_top.f ====
hw/csr_issue_pkg.sv
hw/csr_iq_entry.sv
hw/csr_iq_alloc.sv
hw/csr_iq_select.sv
hw/csr_exec_unit.sv
hw/csr_issue_top.sv
tb/csr_issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the csr issue testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f csr_issue_top.f \
    --top-module csr_issue_tb \
    -o csr_issue_sim

./obj_dir/csr_issue_sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb/csr_issue_tb.sv ====
`timescale 1ns/10ps

module csr_issue_tb;

    localparam logic [31:0] SEED = 32'hcfbd_796a;
    localparam int TIMEOUT = 500;   // cycles per wait
    localparam csr_issue_pkg::rob_idx_t ROB_ONE = csr_issue_pkg::rob_idx_t'(1);

    typedef struct packed {
        csr_issue_pkg::xlen_t old_val;
        csr_issue_pkg::xlen_t new_val;
    } csr_result_t;

    logic                    clk;
    logic                    rst;
    logic                    disp_en;
    csr_issue_pkg::csr_uop_t disp_uop;
    csr_issue_pkg::rob_idx_t commit_rob_idx;
    logic                    redirect;
    csr_issue_pkg::rob_idx_t redirect_idx;
    logic                    full;
    logic                    wb_valid;
    logic                    wb_we;
    csr_issue_pkg::preg_t    wb_rd;
    csr_issue_pkg::rob_idx_t wb_rob_idx;
    csr_issue_pkg::xlen_t    wb_data;
    csr_issue_pkg::xlen_t    trap_inst;

    csr_issue_pkg::csr_uop_t exp_q [$];   // in flight with the oldest first
    csr_issue_pkg::xlen_t    model_csr [csr_issue_pkg::CSR_COUNT];
    csr_issue_pkg::rob_idx_t next_rob;
    csr_issue_pkg::rob_idx_t hold_idx;
    csr_issue_pkg::rob_idx_t last_wb_rob;
    logic                    hold_commit;
    logic                    expect_quiet;
    logic [31:0]             stim_state;
    int                      wb_count;
    int                      advanced_count;

    csr_issue_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .disp_en        (disp_en),
        .disp_uop       (disp_uop),
        .commit_rob_idx (commit_rob_idx),
        .redirect       (redirect),
        .redirect_idx   (redirect_idx),
        .full           (full),
        .wb_valid       (wb_valid),
        .wb_we          (wb_we),
        .wb_rd          (wb_rd),
        .wb_rob_idx     (wb_rob_idx),
        .wb_data        (wb_data),
        .trap_inst      (trap_inst)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // old value goes to rd and the new value lands in the csr
    function automatic csr_result_t csr_ref(
        input csr_issue_pkg::xlen_t    csrs [csr_issue_pkg::CSR_COUNT],
        input csr_issue_pkg::csr_uop_t u
    );
        csr_result_t r;
        r.old_val = csrs[u.csr_addr];
        case (u.op)
            csr_issue_pkg::CSR_RW: r.new_val = u.src;
            csr_issue_pkg::CSR_RS: r.new_val = r.old_val | u.src;
            csr_issue_pkg::CSR_RC: r.new_val = r.old_val & ~u.src;
            default:               r.new_val = r.old_val;
        endcase
        return r;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("Mismatch at %0t ns: %s got 0x%08h, expected 0x%08h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic random_uop(output csr_issue_pkg::csr_uop_t u);
        logic [31:0] r;
        stim_state = lcg_step(stim_state);
        r          = stim_state;
        u.we       = r[31];
        u.rd       = r[30:25];
        u.csr_addr = r[24:22];
        u.op       = csr_issue_pkg::csr_op_e'(2'(r[21:14] % 8'd3));
        u.rob_idx  = next_rob;
        stim_state = lcg_step(stim_state);
        u.src      = stim_state;
        stim_state = lcg_step(stim_state);
        u.inst     = stim_state;
    endtask

    // holds disp_en until the queue takes the uop
    task automatic dispatch_uop(input csr_issue_pkg::csr_uop_t u);
        int waited;
        waited = 0;
        @(posedge clk);
        disp_en  <= 1'b1;
        disp_uop <= u;
        @(negedge clk);
        while (full) begin
            if (waited == TIMEOUT) begin
                stop_with_error("dispatch stuck because full never dropped");
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        disp_en <= 1'b0;
        exp_q.push_back(u);
        next_rob = next_rob + ROB_ONE;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        @(negedge clk);
        while (exp_q.size() != 0 || advanced_count != wb_count) begin
            if (waited == TIMEOUT) begin
                stop_with_error("outstanding uops never wrote back");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // commit pointer parked on an older, non-csr instruction
    task automatic hold_at(input csr_issue_pkg::rob_idx_t idx);
        @(negedge clk);
        hold_idx     = idx;
        hold_commit  = 1'b1;
        expect_quiet = 1'b1;
        @(posedge clk);
    endtask

    task automatic release_to(input csr_issue_pkg::rob_idx_t idx);
        @(negedge clk);
        hold_idx     = idx;
        expect_quiet = 1'b0;
        @(negedge clk);
        hold_commit = 1'b0;
    endtask

    task automatic flush_from(input csr_issue_pkg::rob_idx_t idx);
        csr_issue_pkg::csr_uop_t kept [$];
        @(posedge clk);
        redirect     <= 1'b1;
        redirect_idx <= idx;
        foreach (exp_q[i]) begin
            if (csr_issue_pkg::rob_is_older(exp_q[i].rob_idx, idx)) begin
                kept.push_back(exp_q[i]);
            end
        end
        exp_q    = kept;
        next_rob = idx;   // rob rolls back too
        @(posedge clk);
        redirect <= 1'b0;
        @(negedge clk);
        check_value("full after redirect", 32'(full), 32'd0);
    endtask

    // ----------------------------------------------------------------------
    // rob model that moves the commit pointer after each writeback
    // ----------------------------------------------------------------------
    initial begin : rob_proc
        logic [31:0] delay_state;
        commit_rob_idx = '0;
        advanced_count = 0;
        delay_state    = SEED;
        forever begin
            @(posedge clk);
            if (hold_commit) begin
                commit_rob_idx <= hold_idx;
            end else if (advanced_count != wb_count) begin
                delay_state = lcg_step(delay_state);
                repeat (int'(delay_state[31:30])) @(posedge clk);
                commit_rob_idx <= last_wb_rob + ROB_ONE;
                advanced_count = wb_count;
            end
        end
    end

    // ----------------------------------------------------------------------
    // writeback compare
    // ----------------------------------------------------------------------
    initial begin : compare_proc
        csr_issue_pkg::csr_uop_t u;
        csr_result_t r;
        wb_count    = 0;
        last_wb_rob = '0;
        for (int i = 0; i < csr_issue_pkg::CSR_COUNT; i++) begin
            model_csr[i] = '0;
        end
        forever begin
            @(negedge clk);
            if (!rst && wb_valid) begin
                if (expect_quiet) begin
                    stop_with_error("writeback while commit pointer was behind the queue head");
                end else if (exp_q.size() == 0) begin
                    stop_with_error("writeback with no uop outstanding");
                end else begin
                    u = exp_q.pop_front();
                    r = csr_ref(model_csr, u);
                    check_value("wb_rob_idx", 32'(wb_rob_idx), 32'(u.rob_idx));
                    check_value("wb_rd", 32'(wb_rd), 32'(u.rd));
                    check_value("wb_we", 32'(wb_we), 32'(u.we));
                    check_value("wb_data", wb_data, r.old_val);
                    check_value("trap_inst", trap_inst, u.inst);
                    model_csr[u.csr_addr] = r.new_val;
                    last_wb_rob = u.rob_idx;
                    wb_count++;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin : main_proc
        csr_issue_pkg::csr_uop_t u;
        csr_issue_pkg::rob_idx_t base;
        rst          = 1'b1;
        disp_en      = 1'b0;
        disp_uop     = '0;
        redirect     = 1'b0;
        redirect_idx = '0;
        hold_commit  = 1'b0;
        hold_idx     = '0;
        expect_quiet = 1'b0;
        next_rob     = '0;
        stim_state   = SEED;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("full after reset", 32'(full), 32'd0);
        check_value("wb_valid after reset", 32'(wb_valid), 32'd0);
        check_value("trap_inst after reset", trap_inst, 32'd0);

        repeat (40) begin
            random_uop(u);
            dispatch_uop(u);
            repeat (int'(stim_state[31:30])) @(posedge clk);   // dispatch gap
        end
        wait_drained();

        // fill the queue while the head may not issue and bounce a fifth one
        base = next_rob;
        hold_at(next_rob - ROB_ONE);
        repeat (4) begin
            random_uop(u);
            dispatch_uop(u);
        end
        @(negedge clk);
        check_value("full after four dispatches", 32'(full), 32'd1);
        random_uop(u);
        @(posedge clk);
        disp_en  <= 1'b1;
        disp_uop <= u;
        repeat (6) begin
            @(negedge clk);
            check_value("full while commit held", 32'(full), 32'd1);
        end
        @(posedge clk);
        disp_en <= 1'b0;
        release_to(base);
        wait_drained();

        // redirect somewhere inside a full queue
        base = next_rob;
        hold_at(next_rob - ROB_ONE);
        repeat (4) begin
            random_uop(u);
            dispatch_uop(u);
        end
        stim_state = lcg_step(stim_state);
        flush_from(base + csr_issue_pkg::rob_idx_t'(stim_state[31:30]));
        random_uop(u);
        dispatch_uop(u);
        release_to(base);
        repeat (8) begin
            random_uop(u);
            dispatch_uop(u);
        end
        wait_drained();

        // read back every csr with a set of zero
        for (int a = 0; a < csr_issue_pkg::CSR_COUNT; a++) begin
            u          = '0;
            u.we       = 1'b1;
            u.rd       = csr_issue_pkg::preg_t'(a);
            u.rob_idx  = next_rob;
            u.csr_addr = csr_issue_pkg::csr_addr_t'(a);
            u.op       = csr_issue_pkg::CSR_RS;
            u.inst     = 32'h0000_2073 | (32'(a) << 20);
            dispatch_uop(u);
        end
        wait_drained();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== hw/csr_issue_top.sv ====
`timescale 1ns/10ps

module csr_issue_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    disp_en,
    input  csr_issue_pkg::csr_uop_t disp_uop,
    input  csr_issue_pkg::rob_idx_t commit_rob_idx,
    input  logic                    redirect,
    input  csr_issue_pkg::rob_idx_t redirect_idx,
    output logic                    full,
    output logic                    wb_valid,
    output logic                    wb_we,
    output csr_issue_pkg::preg_t    wb_rd,
    output csr_issue_pkg::rob_idx_t wb_rob_idx,
    output csr_issue_pkg::xlen_t    wb_data,
    output csr_issue_pkg::xlen_t    trap_inst
);

    csr_issue_pkg::iq_mask_t wr_en;
    csr_issue_pkg::csr_uop_t wr_uop;
    csr_issue_pkg::iq_mask_t valid;
    csr_issue_pkg::iq_mask_t kill;
    csr_issue_pkg::iq_mask_t retire;
    csr_issue_pkg::csr_uop_t uops [csr_issue_pkg::IQ_DEPTH];
    csr_issue_pkg::iq_idx_t  head;
    logic                    issue;
    csr_issue_pkg::csr_uop_t issue_uop;

    csr_iq_alloc alloc_i (
        .clk      (clk),
        .rst      (rst),
        .disp_en  (disp_en),
        .disp_uop (disp_uop),
        .redirect (redirect),
        .head     (head),
        .valid    (valid),
        .kill     (kill),
        .full     (full),
        .wr_en    (wr_en),
        .wr_uop   (wr_uop)
    );

    // queue slots
    for (genvar i = 0; i < csr_issue_pkg::IQ_DEPTH; i++) begin : g_entry
        csr_iq_entry entry_i (
            .clk          (clk),
            .rst          (rst),
            .wr_en        (wr_en[i]),
            .wr_uop       (wr_uop),
            .retire       (retire[i]),
            .redirect     (redirect),
            .redirect_idx (redirect_idx),
            .valid        (valid[i]),
            .kill         (kill[i]),
            .uop          (uops[i])
        );
    end

    csr_iq_select select_i (
        .clk            (clk),
        .rst            (rst),
        .valid          (valid),
        .uops           (uops),
        .kill           (kill),
        .commit_rob_idx (commit_rob_idx),
        .redirect       (redirect),
        .head           (head),
        .retire         (retire),
        .issue          (issue),
        .issue_uop      (issue_uop)
    );

    csr_exec_unit exec_i (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .issue_uop  (issue_uop),
        .wb_valid   (wb_valid),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_rob_idx (wb_rob_idx),
        .wb_data    (wb_data),
        .trap_inst  (trap_inst)
    );

endmodule

// ==== hw/csr_exec_unit.sv ====
`timescale 1ns/10ps

module csr_exec_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue,
    input  csr_issue_pkg::csr_uop_t issue_uop,
    output logic                    wb_valid,
    output logic                    wb_we,
    output csr_issue_pkg::preg_t    wb_rd,
    output csr_issue_pkg::rob_idx_t wb_rob_idx,
    output csr_issue_pkg::xlen_t    wb_data,
    output csr_issue_pkg::xlen_t    trap_inst
);

    csr_issue_pkg::xlen_t csr_file [csr_issue_pkg::CSR_COUNT];
    csr_issue_pkg::xlen_t old_val;
    csr_issue_pkg::xlen_t new_val;

    // ----------------------------------------------------------------------
    // read-modify-write
    // ----------------------------------------------------------------------
    assign old_val = csr_file[issue_uop.csr_addr];

    always_comb begin
        case (issue_uop.op)
            csr_issue_pkg::CSR_RW: new_val = issue_uop.src;
            csr_issue_pkg::CSR_RS: new_val = old_val | issue_uop.src;
            csr_issue_pkg::CSR_RC: new_val = old_val & ~issue_uop.src;
            default:               new_val = old_val;   // unused encoding
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < csr_issue_pkg::CSR_COUNT; i++) begin
                csr_file[i] <= '0;
            end
        end else if (issue) begin
            csr_file[issue_uop.csr_addr] <= new_val;
        end
    end

    // ----------------------------------------------------------------------
    // writeback and trap word
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid  <= 1'b0;
            trap_inst <= '0;
        end else begin
            wb_valid <= issue;
            if (issue) begin
                trap_inst <= issue_uop.inst;
            end
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (issue) begin
            wb_we      <= issue_uop.we;
            wb_rd      <= issue_uop.rd;
            wb_rob_idx <= issue_uop.rob_idx;
            wb_data    <= old_val;   // rd gets the value before the write
        end
    end

endmodule

// ==== hw/csr_iq_select.sv ====
`timescale 1ns/10ps

module csr_iq_select (
    input  logic                    clk,
    input  logic                    rst,
    input  csr_issue_pkg::iq_mask_t valid,
    input  csr_issue_pkg::csr_uop_t uops [csr_issue_pkg::IQ_DEPTH],
    input  csr_issue_pkg::iq_mask_t kill,
    input  csr_issue_pkg::rob_idx_t commit_rob_idx,
    input  logic                    redirect,
    output csr_issue_pkg::iq_idx_t  head,
    output csr_issue_pkg::iq_mask_t retire,
    output logic                    issue,
    output csr_issue_pkg::csr_uop_t issue_uop
);

    typedef enum logic {
        S_IDLE,
        S_WRITING
    } state_e;

    state_e state;
    state_e state_n;
    csr_issue_pkg::iq_idx_t  head_q;
    csr_issue_pkg::iq_idx_t  head_n;
    csr_issue_pkg::rob_idx_t issued_rob;
    csr_issue_pkg::csr_uop_t head_uop;
    logic head_oldest;
    logic commit_moved;
    logic head_killed;
    logic do_retire;

    // ----------------------------------------------------------------------
    // head view
    // ----------------------------------------------------------------------
    assign head_uop    = uops[head_q];
    assign head_oldest = valid[head_q] && (head_uop.rob_idx == commit_rob_idx);
    assign head_killed = kill[head_q];

    // only one csr op in flight, and only when it is the oldest instruction
    assign issue     = (state == S_IDLE) && head_oldest && !redirect;
    assign issue_uop = head_uop;

    // commit pointer has moved past the issued op
    assign commit_moved = (issued_rob != commit_rob_idx);
    assign do_retire    = (state == S_WRITING) && commit_moved && !head_killed;
    assign retire       = do_retire ? (csr_issue_pkg::iq_mask_t'(1) << head_q) : '0;

    // ----------------------------------------------------------------------
    // fsm
    // ----------------------------------------------------------------------
    always_comb begin
        state_n = state;
        head_n  = head_q;
        case (state)
            S_IDLE: begin
                if (issue) begin
                    state_n = S_WRITING;
                end
            end
            S_WRITING: begin
                if (head_killed) begin
                    state_n = S_IDLE;   // slot gone so head stays put
                end else if (commit_moved) begin
                    state_n = S_IDLE;
                    head_n  = head_q + csr_issue_pkg::iq_idx_t'(1);
                end
            end
            default: begin
                state_n = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            head_q     <= '0;
            issued_rob <= '0;
        end else begin
            state  <= state_n;
            head_q <= head_n;
            if (issue) begin
                issued_rob <= head_uop.rob_idx;
            end
        end
    end

    assign head = head_q;

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    a_issue_idle: assert property (
        @(posedge clk) disable iff (rst)
        issue |=> ((state == S_WRITING) && !issue)
    ) else $error("csr_iq_select: issue while writing");

    // the retired slot must still hold the op that was issued
    a_retire_writing: assert property (
        @(posedge clk) disable iff (rst)
        (retire != '0) |-> ((state == S_WRITING) && (head_uop.rob_idx == issued_rob))
    ) else $error("csr_iq_select: retire outside writing state");

endmodule

// ==== hw/csr_iq_alloc.sv ====
`timescale 1ns/10ps

module csr_iq_alloc (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    disp_en,
    input  csr_issue_pkg::csr_uop_t disp_uop,
    input  logic                    redirect,
    input  csr_issue_pkg::iq_idx_t  head,
    input  csr_issue_pkg::iq_mask_t valid,
    input  csr_issue_pkg::iq_mask_t kill,
    output logic                    full,
    output csr_issue_pkg::iq_mask_t wr_en,
    output csr_issue_pkg::csr_uop_t wr_uop
);

    localparam int CNT_W = csr_issue_pkg::IQ_IDX_W + 1;

    csr_issue_pkg::iq_idx_t tail;
    csr_issue_pkg::iq_idx_t tail_n;
    logic [CNT_W-1:0] valid_cnt;
    logic [CNT_W-1:0] surv_cnt;
    logic enqueue;

    // ----------------------------------------------------------------------
    // occupancy
    // ----------------------------------------------------------------------
    always_comb begin
        valid_cnt = '0;
        surv_cnt  = '0;
        for (int i = 0; i < csr_issue_pkg::IQ_DEPTH; i++) begin
            valid_cnt = valid_cnt + CNT_W'(valid[i]);
            surv_cnt  = surv_cnt + CNT_W'(valid[i] & ~kill[i]);
        end
    end

    assign full = (valid_cnt == CNT_W'(csr_issue_pkg::IQ_DEPTH));

    // ----------------------------------------------------------------------
    // write strobe
    // ----------------------------------------------------------------------
    assign enqueue = disp_en & ~full & ~redirect;
    assign wr_en   = enqueue ? (csr_issue_pkg::iq_mask_t'(1) << tail) : '0;
    assign wr_uop  = disp_uop;   // broadcast to all slots

    // survivors sit contiguously from head so the tail follows from the count
    always_comb begin
        if (redirect) begin
            tail_n = head + surv_cnt[csr_issue_pkg::IQ_IDX_W-1:0];
        end else if (enqueue) begin
            tail_n = tail + csr_issue_pkg::iq_idx_t'(1);
        end else begin
            tail_n = tail;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail <= '0;
        end else begin
            tail <= tail_n;
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    a_wr_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(wr_en)
    ) else $error("csr_iq_alloc: more than one write strobe");

endmodule

// ==== hw/csr_iq_entry.sv ====
`timescale 1ns/10ps

module csr_iq_entry (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  csr_issue_pkg::csr_uop_t wr_uop,
    input  logic                  retire,
    input  logic                  redirect,
    input  csr_issue_pkg::rob_idx_t redirect_idx,
    output logic                  valid,
    output logic                  kill,
    output csr_issue_pkg::csr_uop_t uop
);

    logic valid_q;
    csr_issue_pkg::csr_uop_t uop_q;
    logic older;

    // ----------------------------------------------------------------------
    // redirect kill
    // ----------------------------------------------------------------------
    assign older = csr_issue_pkg::rob_is_older(uop_q.rob_idx, redirect_idx);
    assign kill  = valid_q & redirect & ~older;   // same or younger dies

    // ----------------------------------------------------------------------
    // slot state
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (wr_en) begin
            valid_q <= 1'b1;
        end else if (kill || retire) begin
            valid_q <= 1'b0;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            uop_q <= wr_uop;
        end
    end

    assign valid = valid_q;
    assign uop   = uop_q;

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    // allocator must never overwrite a live slot
    a_no_overwrite: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> (!valid_q || retire)
    ) else $error("csr_iq_entry: write into occupied slot");

endmodule

// ==== hw/csr_issue_pkg.sv ====
package csr_issue_pkg;

    // ----------------------------------------------------------------------
    // queue and rob sizing
    // ----------------------------------------------------------------------
    localparam int IQ_DEPTH   = 4;
    localparam int IQ_IDX_W   = 2;
    localparam int ROB_IDX_W  = 5;   // 4-bit position plus wrap bit
    localparam int CSR_COUNT  = 8;
    localparam int CSR_ADDR_W = 3;
    localparam int PREG_W     = 6;

    // ----------------------------------------------------------------------
    // vector types
    // ----------------------------------------------------------------------
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;
    typedef logic [IQ_IDX_W-1:0]   iq_idx_t;
    typedef logic [IQ_DEPTH-1:0]   iq_mask_t;
    typedef logic [PREG_W-1:0]     preg_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [31:0]           xlen_t;

    typedef enum logic [1:0] {
        CSR_RW = 2'd0,
        CSR_RS = 2'd1,
        CSR_RC = 2'd2
    } csr_op_e;

    // one csr instruction as it leaves dispatch (81 bits)
    typedef struct packed {
        logic      we;
        preg_t     rd;
        rob_idx_t  rob_idx;
        csr_addr_t csr_addr;
        csr_op_e   op;
        xlen_t     src;        // operand value already read
        xlen_t     inst;       // raw word kept for traps
    } csr_uop_t;

    // ----------------------------------------------------------------------
    // rob age compare
    // ----------------------------------------------------------------------
    // true when a is strictly older than b
    function automatic logic rob_is_older(rob_idx_t a, rob_idx_t b);
        logic same_wrap;
        logic a_low;
        logic a_high;
        same_wrap = (a[ROB_IDX_W-1] == b[ROB_IDX_W-1]);
        a_low     = (a[ROB_IDX_W-2:0] < b[ROB_IDX_W-2:0]);
        a_high    = (a[ROB_IDX_W-2:0] > b[ROB_IDX_W-2:0]);
        if (same_wrap) begin
            return a_low;
        end
        // b has wrapped past a
        return a_high;
    endfunction

endpackage
